// File: rtl/flight_pkg.sv
package flight_pkg;

    // One signed 16-bit word per body axis
    typedef struct packed {
        logic signed [15:0] roll;
        logic signed [15:0] pitch;
        logic signed [15:0] yaw;
    } attitude_t;

    // IMU sample as delivered on each valid strobe
    // Euler angles first, then body rates
    typedef struct packed {
        attitude_t angle;
        attitude_t gyro;
    } imu_sample_t;

    // Pilot stick targets
    typedef struct packed {
        logic [7:0]         throttle;
        logic signed [15:0] roll_target;
        logic signed [15:0] pitch_target;
        logic signed [15:0] yaw_rate_target;
    } pilot_cmd_t;

    // Rate targets and axis corrections share the attitude layout
    typedef attitude_t rate_cmd_t;

    // Proportional gains as right shifts
    localparam int ANGLE_GAIN_SHIFT = 2;
    localparam int RATE_GAIN_SHIFT  = 1;

    // Correction limit per axis, and throttle floor for spinning motors
    localparam int RATE_LIMIT    = 100;
    localparam int IDLE_THROTTLE = 10;

endpackage

// File: rtl/motor_pkg.sv
package motor_pkg;

    // Motor rate, 0 to MOTOR_MAX
    typedef logic [7:0] motor_rate_t;

    // Quad-X motor set
    typedef struct packed {
        motor_rate_t m1;
        motor_rate_t m2;
        motor_rate_t m3;
        motor_rate_t m4;
    } motor_rates_t;

    localparam int MOTOR_MAX = 250;

    // Microsecond pacing derived from sys_clk
    localparam int CYCLES_PER_US = 2;

    // ESC frame and pulse mapping
    // Rate 0 gives 1000 us, rate 250 gives 2000 us
    localparam int FRAME_US     = 2500;
    localparam int PULSE_MIN_US = 1000;
    localparam int US_PER_RATE  = 4;

endpackage

// File: rtl/flight_sequencer.sv
`timescale 1ns/1ps

module flight_sequencer (
    input  logic sys_clk,
    input  logic resetn,
    input  logic imu_valid,
    output logic angle_en,
    output logic rate_en,
    output logic mix_en,
    output logic busy
);

    typedef enum logic [1:0] {
        IDLE,
        RATE,
        MIX
    } seq_state_t;

    seq_state_t state;
    seq_state_t state_nxt;

    // Angle stage fires in the same cycle as the accepted sample
    assign angle_en = imu_valid && (state == IDLE);
    assign rate_en  = (state == RATE);
    assign mix_en   = (state == MIX);

    // High while a pass is in flight
    assign busy = (state != IDLE);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (imu_valid) begin
                    state_nxt = RATE;
                end
            end
            RATE: state_nxt = MIX;
            MIX:  state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Accepted start walks the rate and mix strobes in order
    a_angle_then_rate: assert property (@(posedge sys_clk) disable iff (!resetn)
        angle_en |=> rate_en);

    a_rate_then_mix: assert property (@(posedge sys_clk) disable iff (!resetn)
        rate_en |=> mix_en);

endmodule

// File: rtl/us_tick_timer.sv
`timescale 1ns/1ps

module us_tick_timer (
    input  logic        sys_clk,
    input  logic        resetn,
    output logic [11:0] us_count,
    output logic        frame_start
);

    import motor_pkg::*;

    localparam int PRE_W = (CYCLES_PER_US > 1) ? $clog2(CYCLES_PER_US) : 1;

    logic [PRE_W-1:0] prescale;
    logic             tick;

    // Last sys_clk cycle of each microsecond
    assign tick = (prescale == PRE_W'(CYCLES_PER_US - 1));

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            prescale    <= '0;
            us_count    <= '0;
            frame_start <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            if (tick) begin
                prescale <= '0;
                // Wrap to the next frame
                if (us_count == 12'(FRAME_US - 1)) begin
                    us_count    <= '0;
                    frame_start <= 1'b1;
                end else begin
                    us_count <= us_count + 12'd1;
                end
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

    a_us_range: assert property (@(posedge sys_clk) disable iff (!resetn)
        us_count < 12'(FRAME_US));

endmodule

// File: rtl/angle_stage.sv
`timescale 1ns/1ps

module angle_stage (
    input  logic                   sys_clk,
    input  logic                   resetn,
    input  logic                   angle_en,
    input  flight_pkg::imu_sample_t imu,
    input  flight_pkg::pilot_cmd_t  cmd,
    output flight_pkg::rate_cmd_t   rate_target,
    output flight_pkg::attitude_t   gyro,
    output logic [7:0]              throttle
);

    import flight_pkg::*;

    logic signed [16:0] roll_err;
    logic signed [16:0] pitch_err;
    logic signed [15:0] roll_sat;
    logic signed [15:0] pitch_sat;

    // Clip a 17-bit error back into the 16-bit word
    function automatic logic signed [15:0] sat16(input logic signed [16:0] v);
        if (v > 17'sd32767) begin
            return 16'sh7fff;
        end else if (v < -17'sd32768) begin
            return 16'sh8000;
        end
        return v[15:0];
    endfunction

    // Angle error with one guard bit
    assign roll_err  = {cmd.roll_target[15], cmd.roll_target} -
                       {imu.angle.roll[15], imu.angle.roll};
    assign pitch_err = {cmd.pitch_target[15], cmd.pitch_target} -
                       {imu.angle.pitch[15], imu.angle.pitch};
    assign roll_sat  = sat16(roll_err);
    assign pitch_sat = sat16(pitch_err);

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            rate_target <= '0;
            gyro        <= '0;
            throttle    <= '0;
        end else if (angle_en) begin
            rate_target.roll  <= roll_sat >>> ANGLE_GAIN_SHIFT;
            rate_target.pitch <= pitch_sat >>> ANGLE_GAIN_SHIFT;
            // Yaw is flown in rate mode
            rate_target.yaw   <= cmd.yaw_rate_target;
            // Same sample follows the targets down the chain
            gyro              <= imu.gyro;
            throttle          <= cmd.throttle;
        end
    end

endmodule

// File: rtl/rate_stage.sv
`timescale 1ns/1ps

module rate_stage (
    input  logic                  sys_clk,
    input  logic                  resetn,
    input  logic                  rate_en,
    input  flight_pkg::rate_cmd_t rate_target,
    input  flight_pkg::attitude_t gyro,
    output flight_pkg::rate_cmd_t correction
);

    import flight_pkg::*;

    logic signed [16:0] roll_err;
    logic signed [16:0] pitch_err;
    logic signed [16:0] yaw_err;

    // Gain, then clamp to the correction limit
    function automatic logic signed [15:0] clamp_rate(input logic signed [16:0] e);
        logic signed [16:0] s;
        s = e >>> RATE_GAIN_SHIFT;
        if (s > RATE_LIMIT) begin
            return 16'(RATE_LIMIT);
        end else if (s < -RATE_LIMIT) begin
            return 16'(-RATE_LIMIT);
        end
        return s[15:0];
    endfunction

    // Rate errors kept at 17 bits, no overflow
    assign roll_err  = {rate_target.roll[15], rate_target.roll} - {gyro.roll[15], gyro.roll};
    assign pitch_err = {rate_target.pitch[15], rate_target.pitch} -
                       {gyro.pitch[15], gyro.pitch};
    assign yaw_err   = {rate_target.yaw[15], rate_target.yaw} - {gyro.yaw[15], gyro.yaw};

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            correction <= '0;
        end else if (rate_en) begin
            correction.roll  <= clamp_rate(roll_err);
            correction.pitch <= clamp_rate(pitch_err);
            correction.yaw   <= clamp_rate(yaw_err);
        end
    end

    // Mixer relies on bounded corrections
    a_clamp: assert property (@(posedge sys_clk) disable iff (!resetn)
        (correction.roll  <= RATE_LIMIT) && (correction.roll  >= -RATE_LIMIT) &&
        (correction.pitch <= RATE_LIMIT) && (correction.pitch >= -RATE_LIMIT) &&
        (correction.yaw   <= RATE_LIMIT) && (correction.yaw   >= -RATE_LIMIT));

endmodule

// File: rtl/motor_mixer.sv
`timescale 1ns/1ps

module motor_mixer (
    input  logic                    sys_clk,
    input  logic                    resetn,
    input  logic                    mix_en,
    input  logic [7:0]              throttle,
    input  flight_pkg::rate_cmd_t   correction,
    output motor_pkg::motor_rates_t motor_rates,
    output logic                    mix_valid
);

    import flight_pkg::*;
    import motor_pkg::*;

    logic signed [17:0] t_s;
    logic signed [17:0] p_s;
    logic signed [17:0] r_s;
    logic signed [17:0] y_s;
    logic signed [17:0] sum1;
    logic signed [17:0] sum2;
    logic signed [17:0] sum3;
    logic signed [17:0] sum4;
    logic               idle;

    // Saturate a mix sum into the motor range
    function automatic motor_rate_t mix_clamp(input logic signed [17:0] s);
        if (s < 0) begin
            return '0;
        end else if (s > MOTOR_MAX) begin
            return motor_rate_t'(MOTOR_MAX);
        end
        return s[7:0];
    endfunction

    // Common 18-bit signed frame for throttle and corrections
    assign t_s = {10'd0, throttle};
    assign p_s = {{2{correction.pitch[15]}}, correction.pitch};
    assign r_s = {{2{correction.roll[15]}}, correction.roll};
    assign y_s = {{2{correction.yaw[15]}}, correction.yaw};

    // Quad-X layout
    assign sum1 = t_s + p_s + r_s - y_s;
    assign sum2 = t_s + p_s - r_s + y_s;
    assign sum3 = t_s - p_s - r_s - y_s;
    assign sum4 = t_s - p_s + r_s + y_s;

    // Stick at bottom, all motors stopped
    assign idle = (throttle < 8'(IDLE_THROTTLE));

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            motor_rates <= '0;
            mix_valid   <= 1'b0;
        end else begin
            mix_valid <= mix_en;
            if (mix_en) begin
                if (idle) begin
                    motor_rates <= '0;
                end else begin
                    motor_rates.m1 <= mix_clamp(sum1);
                    motor_rates.m2 <= mix_clamp(sum2);
                    motor_rates.m3 <= mix_clamp(sum3);
                    motor_rates.m4 <= mix_clamp(sum4);
                end
            end
        end
    end

    // PWM mapping assumes rates never pass the top
    a_motor_max: assert property (@(posedge sys_clk) disable iff (!resetn)
        (motor_rates.m1 <= MOTOR_MAX) && (motor_rates.m2 <= MOTOR_MAX) &&
        (motor_rates.m3 <= MOTOR_MAX) && (motor_rates.m4 <= MOTOR_MAX));

endmodule

// File: rtl/pwm_output.sv
`timescale 1ns/1ps

module pwm_output (
    input  logic                    sys_clk,
    input  logic                    resetn,
    input  logic                    frame_start,
    input  logic [11:0]             us_count,
    input  motor_pkg::motor_rates_t motor_rates,
    output logic [3:0]              motor_pwm
);

    import motor_pkg::*;

    motor_rates_t         rates_q;
    motor_rate_t [3:0]    rate_vec;
    logic                 active;

    // Pulse length in microseconds for one rate
    function automatic logic [11:0] pulse_len(input motor_rate_t r);
        return 12'(PULSE_MIN_US + US_PER_RATE * r);
    endfunction

    // Bit 0 drives motor 1
    assign rate_vec = {rates_q.m4, rates_q.m3, rates_q.m2, rates_q.m1};

    // Outputs stay low until the first frame boundary
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            active <= 1'b0;
        end else if (frame_start) begin
            active <= 1'b1;
        end
    end

    // Rates hold for a whole frame
    always_ff @(posedge sys_clk) begin
        if (frame_start) begin
            rates_q <= motor_rates;
        end
    end

    // Frame start cycle is always inside the pulse
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            motor_pwm[i] = frame_start || (active && (us_count < pulse_len(rate_vec[i])));
        end
    end

endmodule

// File: rtl/flight_core.sv
`timescale 1ns/1ps

module flight_core (
    input  logic                    sys_clk,
    input  logic                    resetn,
    input  logic                    imu_valid,
    input  flight_pkg::imu_sample_t imu,
    input  flight_pkg::pilot_cmd_t  cmd,
    output logic [3:0]              motor_pwm,
    output motor_pkg::motor_rates_t motor_rates,
    output logic                    mix_valid,
    output logic                    busy
);

    import flight_pkg::*;

    // Stage strobes
    logic angle_en;
    logic rate_en;
    logic mix_en;

    // Pipeline payload between stages
    rate_cmd_t  rate_target;
    rate_cmd_t  correction;
    attitude_t  gyro;
    logic [7:0] throttle;

    // PWM pacing
    logic [11:0] us_count;
    logic        frame_start;

    flight_sequencer i_seq (
        .sys_clk(sys_clk), .resetn(resetn), .imu_valid(imu_valid),
        .angle_en(angle_en), .rate_en(rate_en), .mix_en(mix_en), .busy(busy));

    us_tick_timer i_timer (
        .sys_clk(sys_clk), .resetn(resetn), .us_count(us_count), .frame_start(frame_start));

    angle_stage i_angle (
        .sys_clk(sys_clk), .resetn(resetn), .angle_en(angle_en), .imu(imu), .cmd(cmd),
        .rate_target(rate_target), .gyro(gyro), .throttle(throttle));

    rate_stage i_rate (
        .sys_clk(sys_clk), .resetn(resetn), .rate_en(rate_en), .rate_target(rate_target),
        .gyro(gyro), .correction(correction));

    motor_mixer i_mixer (
        .sys_clk(sys_clk), .resetn(resetn), .mix_en(mix_en), .throttle(throttle),
        .correction(correction), .motor_rates(motor_rates), .mix_valid(mix_valid));

    pwm_output i_pwm (
        .sys_clk(sys_clk), .resetn(resetn), .frame_start(frame_start), .us_count(us_count),
        .motor_rates(motor_rates), .motor_pwm(motor_pwm));

endmodule

// File: dv/tb_flight_core.sv
`timescale 1ns/1ps

module tb_flight_core;

    import flight_pkg::*;
    import motor_pkg::*;

    localparam int PASS_TIMEOUT  = 20;
    localparam int FRAME_CYCLES  = FRAME_US * CYCLES_PER_US;
    localparam int FRAME_TIMEOUT = 2 * FRAME_CYCLES + 50;

    logic         sys_clk = 1'b0;
    logic         resetn;
    logic         imu_valid;
    imu_sample_t  imu;
    pilot_cmd_t   cmd;
    logic [3:0]   motor_pwm;
    motor_rates_t motor_rates;
    logic         mix_valid;
    logic         busy;

    // Run totals, and snapshots taken at the start of each test
    int checks;
    int errors;
    int tests;
    int test_checks;
    int test_errors;
    motor_rates_t last_exp;

    flight_core i_dut (
        .sys_clk(sys_clk), .resetn(resetn), .imu_valid(imu_valid), .imu(imu), .cmd(cmd),
        .motor_pwm(motor_pwm), .motor_rates(motor_rates), .mix_valid(mix_valid), .busy(busy));

    // 20 ns period
    always #10 sys_clk = ~sys_clk;

    task automatic check_val(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic begin_test();
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s finished: %0d checks, %0d errors", name,
                 checks - test_checks, errors - test_errors);
    endtask

    function automatic int limit(input int v, input int lo, input int hi);
        if (v < lo) begin
            return lo;
        end else if (v > hi) begin
            return hi;
        end
        return v;
    endfunction

    // Mostly small angles and rates, sometimes the full word
    function automatic logic signed [15:0] rand_word();
        if ($urandom_range(3) == 0) begin
            return 16'($urandom);
        end
        return 16'(int'($urandom_range(400)) - 200);
    endfunction

    task automatic rand_sample(output imu_sample_t s, output pilot_cmd_t c, input int thr_max);
        s.angle.roll      = rand_word();
        s.angle.pitch     = rand_word();
        s.angle.yaw       = rand_word();
        s.gyro.roll       = rand_word();
        s.gyro.pitch      = rand_word();
        s.gyro.yaw        = rand_word();
        c.throttle        = 8'($urandom_range(thr_max));
        c.roll_target     = rand_word();
        c.pitch_target    = rand_word();
        c.yaw_rate_target = rand_word();
    endtask

    // Reference control law, angle stage then rate stage then quad-X mix
    task automatic model_pass(input imu_sample_t s, input pilot_cmd_t c,
                              output motor_rates_t m);
        int rt_roll;
        int rt_pitch;
        int rt_yaw;
        int r;
        int p;
        int y;
        int t;
        rt_roll  = limit(int'($signed(c.roll_target)) - int'($signed(s.angle.roll)),
                         -32768, 32767) >>> ANGLE_GAIN_SHIFT;
        rt_pitch = limit(int'($signed(c.pitch_target)) - int'($signed(s.angle.pitch)),
                         -32768, 32767) >>> ANGLE_GAIN_SHIFT;
        rt_yaw   = int'($signed(c.yaw_rate_target));
        r = limit((rt_roll - int'($signed(s.gyro.roll))) >>> RATE_GAIN_SHIFT,
                  -RATE_LIMIT, RATE_LIMIT);
        p = limit((rt_pitch - int'($signed(s.gyro.pitch))) >>> RATE_GAIN_SHIFT,
                  -RATE_LIMIT, RATE_LIMIT);
        y = limit((rt_yaw - int'($signed(s.gyro.yaw))) >>> RATE_GAIN_SHIFT,
                  -RATE_LIMIT, RATE_LIMIT);
        t = int'(c.throttle);
        m = '0;
        if (t >= IDLE_THROTTLE) begin
            m.m1 = 8'(limit(t + p + r - y, 0, MOTOR_MAX));
            m.m2 = 8'(limit(t + p - r + y, 0, MOTOR_MAX));
            m.m3 = 8'(limit(t - p - r - y, 0, MOTOR_MAX));
            m.m4 = 8'(limit(t - p + r + y, 0, MOTOR_MAX));
        end
    endtask

    // One sample through the chain; drop_cycle 1 or 2 adds a second start mid-pass
    task automatic run_pass(input imu_sample_t s, input pilot_cmd_t c, input int drop_cycle);
        motor_rates_t exp;
        imu_sample_t  s2;
        pilot_cmd_t   c2;
        int           lat;
        logic         seen;
        model_pass(s, c, exp);
        rand_sample(s2, c2, 255);
        @(posedge sys_clk);
        imu_valid <= 1'b1;
        imu       <= s;
        cmd       <= c;
        lat  = 0;
        seen = 1'b0;
        while (!seen && lat < PASS_TIMEOUT) begin
            @(negedge sys_clk);
            check_val("busy", (lat == 1 || lat == 2) ? 1 : 0, int'(busy));
            if (mix_valid) begin
                seen = 1'b1;
            end else begin
                @(posedge sys_clk);
                lat++;
                imu_valid <= (lat == drop_cycle);
                if (lat == drop_cycle) begin
                    imu <= s2;
                    cmd <= c2;
                end
            end
        end
        if (!seen) begin
            errors++;
            $display("Timeout: mix_valid did not follow imu_valid within %0d cycles",
                     PASS_TIMEOUT);
        end else begin
            check_val("mix_latency", 3, lat);
            check_val("motor_rates.m1", int'(exp.m1), int'(motor_rates.m1));
            check_val("motor_rates.m2", int'(exp.m2), int'(motor_rates.m2));
            check_val("motor_rates.m3", int'(exp.m3), int'(motor_rates.m3));
            check_val("motor_rates.m4", int'(exp.m4), int'(motor_rates.m4));
        end
        last_exp = exp;
        // Dropped start must not produce a second result
        repeat (6) begin
            @(negedge sys_clk);
            check_val("mix_valid", 0, int'(mix_valid));
        end
    endtask

    // Measure the pulses of the next full frame and the frame period
    task automatic check_pulses(input motor_rates_t r);
        int         len [4];
        int         rate [4];
        logic [3:0] running;
        logic       prev;
        logic       found;
        int         n;
        rate[0] = int'(r.m1);
        rate[1] = int'(r.m2);
        rate[2] = int'(r.m3);
        rate[3] = int'(r.m4);
        @(negedge sys_clk);
        prev  = motor_pwm[0];
        found = 1'b0;
        n     = 0;
        while (!found && n < FRAME_TIMEOUT) begin
            @(negedge sys_clk);
            n++;
            found = motor_pwm[0] && !prev;
            prev  = motor_pwm[0];
        end
        if (!found) begin
            errors++;
            $display("Timeout: no PWM frame start seen on motor 1");
            return;
        end
        // Frame start cycle, all four outputs rise together
        check_val("motor_pwm", 15, int'(motor_pwm));
        running = motor_pwm;
        for (int i = 0; i < 4; i++) begin
            len[i] = 1;
        end
        n = 0;
        while (running != 4'b0 && n < FRAME_TIMEOUT) begin
            @(negedge sys_clk);
            n++;
            for (int i = 0; i < 4; i++) begin
                if (running[i] && motor_pwm[i]) begin
                    len[i]++;
                end else begin
                    running[i] = 1'b0;
                end
            end
        end
        for (int i = 0; i < 4; i++) begin
            check_val($sformatf("pulse_cycles[%0d]", i),
                      (PULSE_MIN_US + US_PER_RATE * rate[i]) * CYCLES_PER_US, len[i]);
        end
        // Next rising edge ends the frame
        prev  = motor_pwm[0];
        found = 1'b0;
        while (!found && n < FRAME_TIMEOUT) begin
            @(negedge sys_clk);
            n++;
            found = motor_pwm[0] && !prev;
            prev  = motor_pwm[0];
        end
        check_val("frame_period", FRAME_CYCLES, n);
    endtask

    initial begin
        imu_sample_t s;
        pilot_cmd_t  c;
        void'($urandom(32'h2e08e9fe));
        checks    = 0;
        errors    = 0;
        tests     = 0;
        resetn    <= 1'b0;
        imu_valid <= 1'b0;
        imu       <= '0;
        cmd       <= '0;
        repeat (8) @(posedge sys_clk);
        resetn <= 1'b1;

        // Outputs quiet until the first frame
        begin_test();
        repeat (16) begin
            @(negedge sys_clk);
            check_val("mix_valid", 0, int'(mix_valid));
            check_val("busy", 0, int'(busy));
            check_val("motor_pwm", 0, int'(motor_pwm));
            check_val("motor_rates", 0, int'(motor_rates));
        end
        end_test("reset_state");

        begin_test();
        repeat (200) begin
            rand_sample(s, c, 255);
            run_pass(s, c, 0);
        end
        end_test("control_pass");

        begin_test();
        repeat (40) begin
            rand_sample(s, c, IDLE_THROTTLE - 1);
            run_pass(s, c, 0);
        end
        end_test("idle_cutoff");

        begin_test();
        for (int k = 0; k < 20; k++) begin
            rand_sample(s, c, 255);
            run_pass(s, c, 1 + (k % 2));
        end
        end_test("dropped_start");

        begin_test();
        repeat (3) begin
            rand_sample(s, c, 255);
            run_pass(s, c, 0);
            check_pulses(last_exp);
        end
        end_test("pulse_width");

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: files.f
rtl/flight_pkg.sv
rtl/motor_pkg.sv
rtl/flight_sequencer.sv
rtl/us_tick_timer.sv
rtl/angle_stage.sv
rtl/rate_stage.sv
rtl/motor_mixer.sv
rtl/pwm_output.sv
rtl/flight_core.sv
dv/tb_flight_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and pass only on the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_flight_core \
    && ./obj_dir/Vtb_flight_core | tee /dev/stderr \
        | grep "Simulation completed successfully" > /dev/null \
    && echo "Result: PASS" \
    || { echo "Result: FAIL"; exit 1; }
